// File: rtl/user_params.svh
`ifndef USER_PARAMS_SVH
`define USER_PARAMS_SVH

// ------------------------------------------------
// GPIO unit sizing
// ------------------------------------------------

// Synchronized GPIO inputs watched by the edge unit
`define USER_GPIO_COUNT 16
// Interrupt lines to the core, each one covers an equal pin group
`define USER_NUM_IRQS 4

// ------------------------------------------------
// Bus and address map
// ------------------------------------------------

// Transactions the demux keeps in flight
`define USER_MAX_TRANS 2
// OBI transaction id width
`define USER_AID_WIDTH 2
// Upper 20 address bits of the GPIO region
`define USER_GPIO_PAGE 20'h20000
// Marker word on every error response
`define USER_ERR_RDATA 32'hBADCAB1E

`endif

// File: rtl/user_pkg.sv
`include "user_params.svh"

package user_pkg;

  // ------------------------------------------------
  // OBI channels
  // ------------------------------------------------

  // Address phase, stable while req waits for gnt
  typedef struct packed {
    logic [31:0]                 addr;
    logic                        we;
    logic [3:0]                  be;
    logic [31:0]                 wdata;
    logic [`USER_AID_WIDTH-1:0]  aid;
  } obi_a_chan_t;

  // Response phase, valid with rvalid
  typedef struct packed {
    logic [31:0]                 rdata;
    logic [`USER_AID_WIDTH-1:0]  rid;
    logic                        err;
  } obi_r_chan_t;

  // ------------------------------------------------
  // Subordinate port
  // ------------------------------------------------

  // Manager to subordinate
  typedef struct packed {
    logic        req;
    obi_a_chan_t a;
  } sbr_obi_req_t;

  // Subordinate to manager, no rready in OBI
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    obi_r_chan_t r;
  } sbr_obi_rsp_t;

  // ------------------------------------------------
  // Address views
  // ------------------------------------------------

  // Page and offset split of a bus address
  typedef struct packed {
    logic [19:0] page;
    logic [11:0] offset;
  } user_addr_fields_t;

  // Same word, flat for the bus or split for decoding
  typedef union packed {
    logic [31:0]       addr;
    user_addr_fields_t f;
  } user_addr_u;

  // ------------------------------------------------
  // Subordinate selection
  // ------------------------------------------------

  // Demux port index
  typedef enum logic {
    USER_SBR_GPIO = 1'b0,
    USER_SBR_ERR  = 1'b1
  } user_sbr_idx_e;

  // Number of demux ports
  localparam int unsigned num_sbr = 2;

endpackage

// File: rtl/user_addr_decode.sv
`timescale 1ns/1ps
`include "user_params.svh"

module user_addr_decode (
  input  user_pkg::user_addr_u    addr_i,
  output user_pkg::user_sbr_idx_e idx_o
);

  // ------------------------------------------------
  // Page compare
  // ------------------------------------------------

  // High when the request falls in the GPIO page
  logic gpio_hit;

  // Only the page field matters, offset goes to the peripheral
  assign gpio_hit = (addr_i.f.page == `USER_GPIO_PAGE);

  // ------------------------------------------------
  // Index select
  // ------------------------------------------------

  always_comb begin
    // Unmapped space ends at the error subordinate
    idx_o = user_pkg::USER_SBR_ERR;
    if (gpio_hit) begin
      idx_o = user_pkg::USER_SBR_GPIO;
    end
  end

endmodule

// File: rtl/user_obi_demux.sv
`timescale 1ns/1ps
`include "user_params.svh"

module user_obi_demux (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  user_pkg::user_sbr_idx_e                       sel_i,
  input  user_pkg::sbr_obi_req_t                        sbr_req_i,
  output user_pkg::sbr_obi_rsp_t                        sbr_rsp_o,
  output user_pkg::sbr_obi_req_t [user_pkg::num_sbr-1:0] mgr_req_o,
  input  user_pkg::sbr_obi_rsp_t [user_pkg::num_sbr-1:0] mgr_rsp_i
);

  // Counter must reach the full transaction limit
  localparam int unsigned cnt_width = $clog2(`USER_MAX_TRANS + 1);

  // Outstanding transactions and the port that owns them
  logic [cnt_width-1:0]    cnt_q;
  logic [cnt_width-1:0]    cnt_d;
  user_pkg::user_sbr_idx_e idx_q;

  // Request may pass to the selected port
  logic allow;
  // Handshake done toward the manager
  logic fire;
  // Response handed back this cycle
  logic ret;

  // ------------------------------------------------
  // Request path
  // ------------------------------------------------

  // Idle demux takes any target
  // Busy demux only stacks more on the locked port, up to the limit
  assign allow = (cnt_q == '0) ||
                 ((sel_i == idx_q) && (cnt_q != cnt_width'(`USER_MAX_TRANS)));

  always_comb begin
    for (int k = 0; k < user_pkg::num_sbr; k++) begin
      // Address channel goes to every port, req to one
      mgr_req_o[k].a   = sbr_req_i.a;
      mgr_req_o[k].req = sbr_req_i.req && allow && (int'(sel_i) == k);
    end
  end

  // Grant straight from the target, masked while stalled
  assign sbr_rsp_o.gnt = allow && mgr_rsp_i[sel_i].gnt;

  // ------------------------------------------------
  // Response path
  // ------------------------------------------------

  // All in-flight transactions sit on the locked port,
  // so its responses come back in grant order
  assign sbr_rsp_o.rvalid = mgr_rsp_i[idx_q].rvalid;
  assign sbr_rsp_o.r      = mgr_rsp_i[idx_q].r;

  // ------------------------------------------------
  // Transaction tracking
  // ------------------------------------------------

  assign fire = sbr_req_i.req && sbr_rsp_o.gnt;
  assign ret  = sbr_rsp_o.rvalid;

  always_comb begin
    cnt_d = cnt_q;
    unique case ({fire, ret})
      // New grant, nothing back
      2'b10: cnt_d = cnt_q + 1'b1;
      // Response drained
      2'b01: cnt_d = cnt_q - 1'b1;
      // Both or neither, level stays
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
      idx_q <= user_pkg::USER_SBR_GPIO;
    end else begin
      cnt_q <= cnt_d;
      // Lock the owner on every grant
      // Same value while busy, new value only from idle
      if (fire) begin
        idx_q <= sel_i;
      end
    end
  end

endmodule

// File: rtl/user_err_sbr.sv
`timescale 1ns/1ps
`include "user_params.svh"

module user_err_sbr (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  user_pkg::sbr_obi_req_t obi_req_i,
  output user_pkg::sbr_obi_rsp_t obi_rsp_o
);

  // Response pipeline stage
  logic                       rvalid_q;
  logic [`USER_AID_WIDTH-1:0] rid_q;

  // ------------------------------------------------
  // Grant
  // ------------------------------------------------

  // Stage drains every cycle since the manager never stalls,
  // so every request is taken at once
  assign obi_rsp_o.gnt = obi_req_i.req;

  // ------------------------------------------------
  // Response stage
  // ------------------------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      // One pulse per granted request
      rvalid_q <= obi_req_i.req;
    end
  end

  // Id of the granted request
  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      rid_q <= obi_req_i.a.aid;
    end
  end

  // Writes are dropped, reads and writes both fail
  assign obi_rsp_o.rvalid  = rvalid_q;
  assign obi_rsp_o.r.rid   = rid_q;
  assign obi_rsp_o.r.err   = 1'b1;
  assign obi_rsp_o.r.rdata = `USER_ERR_RDATA;

endmodule

// File: rtl/user_gpio_irq.sv
`timescale 1ns/1ps
`include "user_params.svh"

module user_gpio_irq (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  user_pkg::sbr_obi_req_t       obi_req_i,
  output user_pkg::sbr_obi_rsp_t       obi_rsp_o,
  input  logic [`USER_GPIO_COUNT-1:0]  gpio_i,
  output logic [`USER_NUM_IRQS-1:0]    irq_o
);

  // Pins per interrupt line
  localparam int unsigned grp_size = `USER_GPIO_COUNT / `USER_NUM_IRQS;

  // Word index of each register
  localparam logic [2:0] reg_in      = 3'd0;
  localparam logic [2:0] reg_rise_en = 3'd1;
  localparam logic [2:0] reg_fall_en = 3'd2;
  localparam logic [2:0] reg_status  = 3'd3;
  localparam logic [2:0] reg_irq_en  = 3'd4;

  // Split view of the bus address
  user_pkg::user_addr_u addr;

  // Register file
  logic [`USER_GPIO_COUNT-1:0] gpio_q;
  logic [`USER_GPIO_COUNT-1:0] rise_en_q;
  logic [`USER_GPIO_COUNT-1:0] fall_en_q;
  logic [`USER_GPIO_COUNT-1:0] status_q;
  logic [`USER_GPIO_COUNT-1:0] irq_en_q;
  logic [`USER_NUM_IRQS-1:0]   irq_q;

  // Access decode
  logic                        in_range;
  logic                        wr;
  logic [2:0]                  sel;
  logic [31:0]                 be_mask;
  logic [`USER_GPIO_COUNT-1:0] wmask;
  logic [`USER_GPIO_COUNT-1:0] wval;

  // Edge and status next state
  logic [`USER_GPIO_COUNT-1:0] edges;
  logic [`USER_GPIO_COUNT-1:0] clr;
  logic [`USER_GPIO_COUNT-1:0] pending;
  logic [`USER_NUM_IRQS-1:0]   irq_d;

  // Read path
  logic [31:0]                 rd_data;
  logic                        rvalid_q;
  logic [31:0]                 rdata_q;
  logic [`USER_AID_WIDTH-1:0]  rid_q;

  // ------------------------------------------------
  // Bus decode
  // ------------------------------------------------

  assign addr = obi_req_i.a.addr;

  // Five words at the page base, the rest reads zero
  assign in_range = (addr.f.offset[11:5] == '0);
  assign sel      = addr.f.offset[4:2];

  // Always granted, so req alone marks the access
  assign obi_rsp_o.gnt = obi_req_i.req;
  assign wr            = obi_req_i.req && obi_req_i.a.we && in_range;

  // Byte enables widened to bits
  assign be_mask = {{8{obi_req_i.a.be[3]}}, {8{obi_req_i.a.be[2]}},
                    {8{obi_req_i.a.be[1]}}, {8{obi_req_i.a.be[0]}}};
  assign wmask   = be_mask[`USER_GPIO_COUNT-1:0];
  assign wval    = obi_req_i.a.wdata[`USER_GPIO_COUNT-1:0] & wmask;

  // ------------------------------------------------
  // Edge capture
  // ------------------------------------------------

  // Compare against last cycle's inputs
  assign edges = (rise_en_q &  gpio_i & ~gpio_q) |
                 (fall_en_q & ~gpio_i &  gpio_q);

  // W1C mask, only on a STATUS write
  assign clr = (wr && (sel == reg_status)) ? wval : '0;

  // Enabled status per pin
  assign pending = status_q & irq_en_q;

  // OR across each pin group
  always_comb begin
    for (int k = 0; k < `USER_NUM_IRQS; k++) begin
      irq_d[k] = |pending[k*grp_size +: grp_size];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_q    <= '0;
      rise_en_q <= '0;
      fall_en_q <= '0;
      status_q  <= '0;
      irq_en_q  <= '0;
      irq_q     <= '0;
    end else begin
      gpio_q   <= gpio_i;
      // New edge wins over a clear on the same bit
      status_q <= (status_q & ~clr) | edges;
      irq_q    <= irq_d;
      // Byte merge into the enable registers
      if (wr && (sel == reg_rise_en)) begin
        rise_en_q <= (rise_en_q & ~wmask) | wval;
      end
      if (wr && (sel == reg_fall_en)) begin
        fall_en_q <= (fall_en_q & ~wmask) | wval;
      end
      if (wr && (sel == reg_irq_en)) begin
        irq_en_q <= (irq_en_q & ~wmask) | wval;
      end
    end
  end

  assign irq_o = irq_q;

  // ------------------------------------------------
  // Read response
  // ------------------------------------------------

  always_comb begin
    rd_data = '0;
    if (in_range && !obi_req_i.a.we) begin
      unique case (sel)
        reg_in:      rd_data[`USER_GPIO_COUNT-1:0] = gpio_i;
        reg_rise_en: rd_data[`USER_GPIO_COUNT-1:0] = rise_en_q;
        reg_fall_en: rd_data[`USER_GPIO_COUNT-1:0] = fall_en_q;
        reg_status:  rd_data[`USER_GPIO_COUNT-1:0] = status_q;
        reg_irq_en:  rd_data[`USER_GPIO_COUNT-1:0] = irq_en_q;
        // Holes in the map read zero
        default:     rd_data = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= obi_req_i.req;
    end
  end

  // Data and id sampled at the grant edge
  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      rdata_q <= rd_data;
      rid_q   <= obi_req_i.a.aid;
    end
  end

  // Never an error, unmapped words just read zero
  assign obi_rsp_o.rvalid  = rvalid_q;
  assign obi_rsp_o.r.rdata = rdata_q;
  assign obi_rsp_o.r.rid   = rid_q;
  assign obi_rsp_o.r.err   = 1'b0;

endmodule

// File: rtl/user_domain.sv
`timescale 1ns/1ps
`include "user_params.svh"

module user_domain (
  input  logic                         clk_i,
  input  logic                         arst_n_i,

  // From the core crossbar
  input  user_pkg::sbr_obi_req_t       user_sbr_obi_req_i,
  output user_pkg::sbr_obi_rsp_t       user_sbr_obi_rsp_o,

  // Already synchronized pins in, interrupts to the core out
  input  logic [`USER_GPIO_COUNT-1:0]  gpio_in_sync_i,
  output logic [`USER_NUM_IRQS-1:0]    interrupts_o
);

  // ------------------------------------------------
  // Subordinate buses
  // ------------------------------------------------

  // Demux side, one entry per subordinate
  user_pkg::sbr_obi_req_t [user_pkg::num_sbr-1:0] all_sbr_req;
  user_pkg::sbr_obi_rsp_t [user_pkg::num_sbr-1:0] all_sbr_rsp;

  // Target chosen from the address
  user_pkg::user_sbr_idx_e user_idx;

  // ------------------------------------------------
  // Decode and demux
  // ------------------------------------------------

  user_addr_decode i_addr_decode (
    .addr_i ( user_sbr_obi_req_i.a.addr ),
    .idx_o  ( user_idx                  )
  );

  user_obi_demux i_obi_demux (
    .clk_i     ( clk_i              ),
    .arst_n_i  ( arst_n_i           ),
    .sel_i     ( user_idx           ),
    .sbr_req_i ( user_sbr_obi_req_i ),
    .sbr_rsp_o ( user_sbr_obi_rsp_o ),
    .mgr_req_o ( all_sbr_req        ),
    .mgr_rsp_i ( all_sbr_rsp        )
  );

  // ------------------------------------------------
  // Subordinates
  // ------------------------------------------------

  // GPIO edge and interrupt unit
  user_gpio_irq i_gpio_irq (
    .clk_i     ( clk_i                                 ),
    .arst_n_i  ( arst_n_i                              ),
    .obi_req_i ( all_sbr_req[user_pkg::USER_SBR_GPIO]  ),
    .obi_rsp_o ( all_sbr_rsp[user_pkg::USER_SBR_GPIO]  ),
    .gpio_i    ( gpio_in_sync_i                        ),
    .irq_o     ( interrupts_o                          )
  );

  // Catch-all for unmapped space
  user_err_sbr i_user_err (
    .clk_i     ( clk_i                                ),
    .arst_n_i  ( arst_n_i                             ),
    .obi_req_i ( all_sbr_req[user_pkg::USER_SBR_ERR]  ),
    .obi_rsp_o ( all_sbr_rsp[user_pkg::USER_SBR_ERR]  )
  );

endmodule

// File: testbench/tb_user_domain.sv
`timescale 1ns/1ps
`include "user_params.svh"

module tb_user_domain;

  localparam int num_tests = 6;
  localparam int grp = `USER_GPIO_COUNT / `USER_NUM_IRQS;
  localparam logic [31:0] gpio_base = {`USER_GPIO_PAGE, 12'h000};

  logic                        clk = 1'b0;
  logic                        arst_n;
  user_pkg::sbr_obi_req_t      bus_req;
  user_pkg::sbr_obi_rsp_t      bus_rsp;
  logic [`USER_GPIO_COUNT-1:0] gpio;
  logic [`USER_NUM_IRQS-1:0]   irq;

  // Requests to issue, expected and received responses
  user_pkg::obi_a_chan_t pend_a[$];
  user_pkg::obi_r_chan_t exp_r[$];
  user_pkg::obi_r_chan_t got_r[$];

  logic [31:0] lcg_state = 32'h61cc;
  string       cur_name;
  int          test_errs;
  int          total_errs = 0;
  int          failed_tests = 0;

  always #5 clk = ~clk;

  user_domain i_dut (
    .clk_i              ( clk     ),
    .arst_n_i           ( arst_n  ),
    .user_sbr_obi_req_i ( bus_req ),
    .user_sbr_obi_rsp_o ( bus_rsp ),
    .gpio_in_sync_i     ( gpio    ),
    .interrupts_o       ( irq     )
  );

  // ------------------------------------------------
  // Helpers and models
  // ------------------------------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Byte merge keeping only the low GPIO bits
  function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                              input logic [31:0] wd, input logic [3:0] be);
    logic [31:0] v;
    v = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        v[8*b +: 8] = wd[8*b +: 8];
      end
    end
    return v & ((32'h1 << `USER_GPIO_COUNT) - 32'h1);
  endfunction

  // GPIO unit owns one page of the map
  function automatic bit in_gpio_page(input logic [31:0] addr);
    return addr[31:12] == `USER_GPIO_PAGE;
  endfunction

  // Pin p feeds interrupt p / grp
  function automatic logic [`USER_NUM_IRQS-1:0] irq_model(
      input logic [`USER_GPIO_COUNT-1:0] st, input logic [`USER_GPIO_COUNT-1:0] en);
    logic [`USER_NUM_IRQS-1:0] v;
    v = '0;
    for (int p = 0; p < `USER_GPIO_COUNT; p++) begin
      if (st[p] && en[p]) begin
        v[p / grp] = 1'b1;
      end
    end
    return v;
  endfunction

  task automatic check_word(input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %h, actual %h", cur_name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_rsp(input user_pkg::obi_r_chan_t exp, input user_pkg::obi_r_chan_t act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected rdata=%h rid=%0d err=%0b, actual rdata=%h rid=%0d err=%0b",
               cur_name, exp.rdata, exp.rid, exp.err, act.rdata, act.rid, act.err);
      test_errs++;
    end
  endtask

  task automatic check_irq(input logic [`USER_NUM_IRQS-1:0] exp,
                           input logic [`USER_NUM_IRQS-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s: expected %b, actual %b", cur_name, exp, act);
      test_errs++;
    end
  endtask

  task automatic report(input string msg);
    $display("ERROR %s: %s", cur_name, msg);
    test_errs++;
  endtask

  task automatic begin_test(input string name);
    cur_name  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      $display("test %s: ok", cur_name);
    end else begin
      $display("test %s: FAIL with %0d errors", cur_name, test_errs);
      failed_tests++;
      total_errs += test_errs;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Queue one access with its expected response
  task automatic push_req(input logic [31:0] addr, input logic we, input logic [3:0] be,
                          input logic [31:0] wdata, input logic [31:0] rdata, input logic err,
                          input logic [`USER_AID_WIDTH-1:0] aid);
    user_pkg::obi_a_chan_t a;
    user_pkg::obi_r_chan_t r;
    a.addr  = addr;
    a.we    = we;
    a.be    = be;
    a.wdata = wdata;
    a.aid   = aid;
    r.rdata = rdata;
    r.rid   = aid;
    r.err   = err;
    pend_a.push_back(a);
    exp_r.push_back(r);
  endtask

  // ------------------------------------------------
  // Bus driver
  // ------------------------------------------------

  // req stays high until every queued access is granted
  task automatic run_and_check();
    int                    sent;
    bit                    granted;
    bit                    granted_prev;
    bit                    want_gnt;
    user_pkg::obi_r_chan_t e;
    sent         = 0;
    granted_prev = 1'b0;
    got_r.delete();
    while (got_r.size() < exp_r.size()) begin
      bus_req.req = (sent < pend_a.size());
      if (sent < pend_a.size()) begin
        bus_req.a = pend_a[sent];
      end
      // Mid-cycle sample with handshake signals settled
      @(negedge clk);
      granted  = bus_req.req && bus_rsp.gnt;
      want_gnt = bus_req.req;
      // Region switch behind a pending response waits one cycle
      if (want_gnt && granted_prev && (sent > 0)) begin
        if (in_gpio_page(pend_a[sent].addr) != in_gpio_page(pend_a[sent - 1].addr)) begin
          want_gnt = 1'b0;
        end
      end
      if (bus_rsp.gnt !== want_gnt) begin
        report("gnt did not come in the cycle the bus timing allows");
      end
      // Every grant answered exactly one cycle later
      if (bus_rsp.rvalid !== granted_prev) begin
        report("rvalid did not follow its grant by one cycle");
      end
      if (bus_rsp.rvalid) begin
        got_r.push_back(bus_rsp.r);
      end
      granted_prev = granted;
      @(posedge clk);
      #1;
      if (granted) begin
        sent++;
      end
    end
    bus_req.req = 1'b0;
    if (sent != pend_a.size()) begin
      report("responses arrived for requests that were never granted");
    end
    @(negedge clk);
    if (bus_rsp.rvalid) begin
      report("extra response after the last request");
    end
    foreach (got_r[i]) begin
      e = exp_r[i];
      // Write data returned is not defined
      if (pend_a[i].we) begin
        e.rdata = got_r[i].rdata;
      end
      check_rsp(e, got_r[i]);
    end
    pend_a.delete();
    exp_r.delete();
    @(posedge clk);
    #1;
  endtask

  // ------------------------------------------------
  // Directed tests
  // ------------------------------------------------

  task automatic test_reset();
    begin_test("reset_state");
    repeat (10) begin
      @(negedge clk);
      check_word(32'h0, {30'h0, bus_rsp.gnt, bus_rsp.rvalid});
      check_irq('0, irq);
    end
    @(posedge clk);
    #1;
    arst_n = 1'b1;
    // RISE_EN, FALL_EN, STATUS, IRQ_EN
    for (int k = 1; k < 5; k++) begin
      push_req(gpio_base + 32'(4 * k), 1'b0, 4'hF, 32'h0, 32'h0, 1'b0, 2'(k));
    end
    run_and_check();
    check_irq('0, irq);
    end_test();
  endtask

  task automatic test_reg_access();
    logic [31:0] model [3];
    logic [31:0] wd;
    logic [31:0] ctl;
    logic [31:0] addr;
    int          r;
    begin_test("reg_access");
    foreach (model[j]) begin
      model[j] = '0;
    end
    for (int i = 0; i < 12; i++) begin
      r    = i % 3;
      wd   = lcg_next();
      ctl  = lcg_next();
      addr = gpio_base + ((r == 2) ? 32'h10 : 32'(4 * r + 4));
      model[r] = merge_bytes(model[r], wd, ctl[3:0]);
      push_req(addr, 1'b1, ctl[3:0], wd, 32'h0, 1'b0, ctl[5:4]);
      push_req(addr, 1'b0, 4'hF, 32'h0, model[r], 1'b0, ctl[7:6]);
    end
    run_and_check();
    end_test();
  endtask

  task automatic test_err_region();
    logic [31:0] addr;
    logic [31:0] ctl;
    begin_test("err_region");
    for (int i = 0; i < 8; i++) begin
      addr = (i == 0) ? 32'h0 : (i == 1) ? (gpio_base + 32'h1000) : lcg_next();
      // Keep random addresses off the GPIO page
      if (addr[31:12] == `USER_GPIO_PAGE) begin
        addr[31] = ~addr[31];
      end
      ctl = lcg_next();
      push_req(addr, i[0], ctl[3:0], ctl, `USER_ERR_RDATA, 1'b1, ctl[5:4]);
    end
    run_and_check();
    end_test();
  endtask

  task automatic test_edge_irq();
    logic [`USER_GPIO_COUNT-1:0] rise_m;
    logic [`USER_GPIO_COUNT-1:0] fall_m;
    logic [`USER_GPIO_COUNT-1:0] en_m;
    logic [`USER_GPIO_COUNT-1:0] stat_m;
    logic [`USER_GPIO_COUNT-1:0] nxt;
    logic [`USER_GPIO_COUNT-1:0] clr;
    begin_test("edge_irq");
    rise_m = 16'hA5F0;
    fall_m = 16'h0F5A;
    en_m   = 16'hF0F0;
    stat_m = '0;
    push_req(gpio_base + 32'h04, 1'b1, 4'hF, 32'(rise_m), 32'h0, 1'b0, 2'd0);
    push_req(gpio_base + 32'h08, 1'b1, 4'hF, 32'(fall_m), 32'h0, 1'b0, 2'd1);
    push_req(gpio_base + 32'h10, 1'b1, 4'hF, 32'(en_m), 32'h0, 1'b0, 2'd2);
    run_and_check();
    // All high, then a mix, then all low
    for (int i = 0; i < 3; i++) begin
      nxt = (i == 0) ? 16'hFFFF : (i == 1) ? 16'h5A3C : 16'h0000;
      stat_m |= (rise_m & nxt & ~gpio) | (fall_m & ~nxt & gpio);
      gpio = nxt;
      idle(2);
      push_req(gpio_base + 32'h0C, 1'b0, 4'hF, 32'h0, 32'(stat_m), 1'b0, 2'(i));
      run_and_check();
      check_irq(irq_model(stat_m, en_m), irq);
    end
    // Partial then full W1C
    for (int i = 0; i < 2; i++) begin
      clr = (i == 0) ? 16'h00F0 : 16'hFFFF;
      stat_m &= ~clr;
      push_req(gpio_base + 32'h0C, 1'b1, 4'hF, 32'(clr), 32'h0, 1'b0, 2'(i));
      push_req(gpio_base + 32'h0C, 1'b0, 4'hF, 32'h0, 32'(stat_m), 1'b0, 2'(i + 1));
      run_and_check();
      idle(1);
      check_irq(irq_model(stat_m, en_m), irq);
    end
    end_test();
  endtask

  task automatic test_ordering();
    logic [31:0] ctl;
    begin_test("ordering");
    // Pattern G E G G E G ... forces target switches and stacking
    for (int i = 0; i < 12; i++) begin
      ctl = lcg_next();
      if (i % 3 != 1) begin
        // IRQ_EN as left by the edge test
        push_req(gpio_base + 32'h10, 1'b0, 4'hF, 32'h0, 32'h0000_F0F0, 1'b0, 2'(i));
      end else begin
        // Odd page number never hits the GPIO page
        push_req({ctl[31:13], 1'b1, ctl[11:0]}, i[2], 4'hF, ctl, `USER_ERR_RDATA, 1'b1, 2'(i));
      end
    end
    run_and_check();
    end_test();
  endtask

  task automatic test_in_reg();
    logic [31:0] ctl;
    begin_test("in_reg");
    for (int i = 0; i < 8; i++) begin
      ctl  = lcg_next();
      gpio = ctl[`USER_GPIO_COUNT-1:0];
      push_req(gpio_base, 1'b0, 4'hF, 32'h0, 32'(gpio), 1'b0, 2'(i));
      run_and_check();
    end
    end_test();
  endtask

  // ------------------------------------------------
  // Sequence and watchdog
  // ------------------------------------------------

  initial begin
    arst_n  = 1'b0;
    bus_req = '0;
    gpio    = '0;
    test_reset();
    test_reg_access();
    test_err_region();
    test_edge_irq();
    test_ordering();
    test_in_reg();
    $display("summary: %0d tests run, %0d with errors, %0d checks wrong",
             num_tests, failed_tests, total_errs);
    if (failed_tests == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    repeat (num_tests * 2000) @(posedge clk);
    $display("timeout: the run took too long, a handshake never completed in %s", cur_name);
    $display("tests failed");
    $finish;
  end

endmodule

// File: sources.f
+incdir+rtl
rtl/user_pkg.sv
rtl/user_addr_decode.sv
rtl/user_obi_demux.sv
rtl/user_err_sbr.sv
rtl/user_gpio_irq.sv
rtl/user_domain.sv
testbench/tb_user_domain.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the user domain testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module tb_user_domain \
  -o sim_user_domain

./obj_dir/sim_user_domain | tee sim.log

if grep -q "tests failed" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi

echo "simulation clean, see sim.log"
